// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define XLEN 32

// unified memory depth in words
`define MEM_WORDS 1024

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: verilog/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0] data_t;
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [4:0]       reg_addr_t;

    typedef enum logic {DISABLE = 1'b0, ENABLE = 1'b1} enable_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_PASS_B
    } alu_op_t;

    typedef enum logic {CMP_EQ, CMP_NE} cmp_op_t;
    typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_t;
    typedef enum logic {SRC2_RS2, SRC2_IMM} src2_sel_t;
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} alu_data_sel_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_NEXT} wb_data_sel_t;

    // base opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // all-zero value is a bubble
    typedef struct packed {
        enable_t      jump;
        enable_t      jalr;
        enable_t      branch;
        alu_op_t      alu_op;
        cmp_op_t      cmp_op;
        src1_sel_t    src1_sel;
        src2_sel_t    src2_sel;
        enable_t      mem_read;
        enable_t      mem_write;
        enable_t      reg_write;
        wb_data_sel_t wb_data_sel;
    } ctrl_t;

    typedef struct packed {
        addr_t pc;
        addr_t pc_next;
        data_t instruction;
    } if_id_bus_t;

    typedef struct packed {
        addr_t     pc;
        addr_t     pc_next;
        data_t     rs1_data;
        data_t     rs2_data;
        data_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_bus_t;

    typedef struct packed {
        data_t        alu_result;
        data_t        mem_write_data;
        reg_addr_t    rd;
        addr_t        pc_next;
        enable_t      mem_read;
        enable_t      mem_write;
        enable_t      reg_write;
        wb_data_sel_t wb_data_sel;
    } ex_mem_bus_t;

    typedef struct packed {
        data_t        alu_result;
        data_t        mem_read_data;
        reg_addr_t    rd;
        addr_t        pc_next;
        enable_t      reg_write;
        wb_data_sel_t wb_data_sel;
    } mem_wb_bus_t;

    typedef struct packed {
        addr_t   addr;
        data_t   wdata;
        enable_t wen;
        enable_t ren;
    } mem_req_t;

endpackage

// File: verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::data_t     instruction_i,
    output cpu_pkg::reg_addr_t rs1_o,
    output cpu_pkg::reg_addr_t rs2_o,
    output cpu_pkg::reg_addr_t rd_o,
    output cpu_pkg::data_t     imm_o,
    output cpu_pkg::ctrl_t     ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign rd_o   = instruction_i[11:7];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        case (opcode)
            cpu_pkg::OP_R: begin
                ctrl_o.reg_write = cpu_pkg::ENABLE;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = funct7[5] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b111:  ctrl_o.alu_op = cpu_pkg::ALU_AND;
                    3'b110:  ctrl_o.alu_op = cpu_pkg::ALU_OR;
                    3'b010:  ctrl_o.alu_op = cpu_pkg::ALU_SLT;
                    default: ctrl_o = '0;
                endcase
            end
            cpu_pkg::OP_IMM: begin
                // addi only
                imm_o = {{20{instruction_i[31]}}, instruction_i[31:20]};
                if (funct3 == 3'b000) begin
                    ctrl_o.src2_sel  = cpu_pkg::SRC2_IMM;
                    ctrl_o.reg_write = cpu_pkg::ENABLE;
                end
            end
            cpu_pkg::OP_LUI: begin
                imm_o = {instruction_i[31:12], 12'b0};
                ctrl_o.alu_op    = cpu_pkg::ALU_PASS_B;
                ctrl_o.src2_sel  = cpu_pkg::SRC2_IMM;
                ctrl_o.reg_write = cpu_pkg::ENABLE;
            end
            cpu_pkg::OP_LOAD: begin
                imm_o = {{20{instruction_i[31]}}, instruction_i[31:20]};
                ctrl_o.src2_sel    = cpu_pkg::SRC2_IMM;
                ctrl_o.mem_read    = cpu_pkg::ENABLE;
                ctrl_o.reg_write   = cpu_pkg::ENABLE;
                ctrl_o.wb_data_sel = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OP_STORE: begin
                imm_o = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
                ctrl_o.src2_sel  = cpu_pkg::SRC2_IMM;
                ctrl_o.mem_write = cpu_pkg::ENABLE;
            end
            cpu_pkg::OP_BRANCH: begin
                imm_o = {{20{instruction_i[31]}}, instruction_i[7], instruction_i[30:25],
                         instruction_i[11:8], 1'b0};
                ctrl_o.branch = cpu_pkg::ENABLE;
                ctrl_o.cmp_op = funct3[0] ? cpu_pkg::CMP_NE : cpu_pkg::CMP_EQ;
                // only beq and bne
                if (funct3[2:1] != 2'b00) begin
                    ctrl_o = '0;
                end
            end
            cpu_pkg::OP_JAL: begin
                imm_o = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                         instruction_i[30:21], 1'b0};
                ctrl_o.jump        = cpu_pkg::ENABLE;
                ctrl_o.reg_write   = cpu_pkg::ENABLE;
                ctrl_o.wb_data_sel = cpu_pkg::WB_PC_NEXT;
            end
            cpu_pkg::OP_JALR: begin
                imm_o = {{20{instruction_i[31]}}, instruction_i[31:20]};
                ctrl_o.jump        = cpu_pkg::ENABLE;
                ctrl_o.jalr        = cpu_pkg::ENABLE;
                ctrl_o.reg_write   = cpu_pkg::ENABLE;
                ctrl_o.wb_data_sel = cpu_pkg::WB_PC_NEXT;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               wen_i,
    input  cpu_pkg::reg_addr_t rs1_i,
    input  cpu_pkg::reg_addr_t rs2_i,
    input  cpu_pkg::reg_addr_t rd_i,
    input  cpu_pkg::data_t     rd_data_i,
    output cpu_pkg::data_t     rs1_data_o,
    output cpu_pkg::data_t     rs2_data_o
);

    cpu_pkg::data_t regs [32];

    always_ff @(posedge clk) begin
        if (wen_i && rd_i != '0) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // write-first bypass covers WB to ID
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (wen_i && rd_i == rs1_i) ? rd_data_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (wen_i && rd_i == rs2_i) ? rd_data_i : regs[rs2_i];

endmodule

// File: verilog/execute.sv
`timescale 1ns/1ps

module execute (
    input  cpu_pkg::id_ex_bus_t    id_ex_i,
    input  cpu_pkg::data_t         mem_forward_i,
    input  cpu_pkg::data_t         wb_forward_i,
    input  cpu_pkg::alu_data_sel_t rs1_sel_i,
    input  cpu_pkg::alu_data_sel_t rs2_sel_i,
    output cpu_pkg::data_t         alu_result_o,
    output cpu_pkg::data_t         store_data_o,
    output cpu_pkg::data_t         pc_target_o,
    output logic                   redirect_o
);

    cpu_pkg::data_t rs1_val;
    cpu_pkg::data_t rs2_val;
    cpu_pkg::data_t op_a;
    cpu_pkg::data_t op_b;
    logic           taken;

    always_comb begin
        case (rs1_sel_i)
            cpu_pkg::FWD_MEM: rs1_val = mem_forward_i;
            cpu_pkg::FWD_WB:  rs1_val = wb_forward_i;
            default:          rs1_val = id_ex_i.rs1_data;
        endcase
        case (rs2_sel_i)
            cpu_pkg::FWD_MEM: rs2_val = mem_forward_i;
            cpu_pkg::FWD_WB:  rs2_val = wb_forward_i;
            default:          rs2_val = id_ex_i.rs2_data;
        endcase
    end

    assign op_a = (id_ex_i.ctrl.src1_sel == cpu_pkg::SRC1_PC) ? id_ex_i.pc : rs1_val;
    assign op_b = (id_ex_i.ctrl.src2_sel == cpu_pkg::SRC2_IMM) ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            cpu_pkg::ALU_SUB:    alu_result_o = op_a - op_b;
            cpu_pkg::ALU_AND:    alu_result_o = op_a & op_b;
            cpu_pkg::ALU_OR:     alu_result_o = op_a | op_b;
            cpu_pkg::ALU_SLT:    alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::ALU_PASS_B: alu_result_o = op_b;
            default:             alu_result_o = op_a + op_b;
        endcase
    end

    // branch compare works on forwarded registers
    assign taken = (id_ex_i.ctrl.cmp_op == cpu_pkg::CMP_EQ) ? (rs1_val == rs2_val) :
                                                              (rs1_val != rs2_val);

    assign pc_target_o = (id_ex_i.ctrl.jalr == cpu_pkg::ENABLE) ?
                         ((rs1_val + id_ex_i.imm) & ~32'd1) : (id_ex_i.pc + id_ex_i.imm);

    assign redirect_o   = (id_ex_i.ctrl.jump == cpu_pkg::ENABLE) ||
                          ((id_ex_i.ctrl.branch == cpu_pkg::ENABLE) && taken);
    assign store_data_o = rs2_val;

endmodule

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t     rs1_id_i,
    input  cpu_pkg::reg_addr_t     rs2_id_i,
    input  cpu_pkg::id_ex_bus_t    id_ex_i,
    input  cpu_pkg::reg_addr_t     rd_mem_i,
    input  cpu_pkg::reg_addr_t     rd_wb_i,
    input  logic                   reg_write_mem_i,
    input  logic                   reg_write_wb_i,
    input  logic                   redirect_i,
    output logic                   stall_if_o,
    output logic                   flush_if_id_o,
    output logic                   flush_id_ex_o,
    output cpu_pkg::alu_data_sel_t rs1_sel_o,
    output cpu_pkg::alu_data_sel_t rs2_sel_o
);

    logic load_use;

    function automatic cpu_pkg::alu_data_sel_t fwd_sel(cpu_pkg::reg_addr_t rs);
        if (rs == '0) begin
            return cpu_pkg::FWD_REG;
        end
        // the younger result in MEM wins
        if (reg_write_mem_i && rd_mem_i == rs) begin
            return cpu_pkg::FWD_MEM;
        end
        if (reg_write_wb_i && rd_wb_i == rs) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_REG;
    endfunction

    assign load_use = (id_ex_i.ctrl.mem_read == cpu_pkg::ENABLE) && (id_ex_i.rd != '0) &&
                      ((id_ex_i.rd == rs1_id_i) || (id_ex_i.rd == rs2_id_i));

    assign stall_if_o    = load_use;
    assign flush_if_id_o = redirect_i;
    assign flush_id_ex_o = redirect_i || load_use;

    always_comb begin
        rs1_sel_o = fwd_sel(id_ex_i.rs1);
        rs2_sel_o = fwd_sel(id_ex_i.rs2);
    end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              global_stall_c_i,
    // master 0, instruction fetch
    output cpu_pkg::mem_req_t imem_req_o,
    input  cpu_pkg::data_t    imem_data_i,
    // master 1, loads and stores
    output cpu_pkg::mem_req_t dmem_req_o,
    input  cpu_pkg::data_t    dmem_read_data_i
);

    cpu_pkg::addr_t         pc_q;
    cpu_pkg::if_id_bus_t    if_id_q;
    cpu_pkg::id_ex_bus_t    id_ex_d;
    cpu_pkg::id_ex_bus_t    id_ex_q;
    cpu_pkg::ex_mem_bus_t   ex_mem_q;
    cpu_pkg::mem_wb_bus_t   mem_wb_q;
    cpu_pkg::data_t         alu_result_ex;
    cpu_pkg::data_t         store_data_ex;
    cpu_pkg::data_t         pc_target_ex;
    logic                   redirect_ex;
    logic                   stall_if;
    logic                   flush_if_id;
    logic                   flush_id_ex;
    cpu_pkg::alu_data_sel_t rs1_sel_ex;
    cpu_pkg::alu_data_sel_t rs2_sel_ex;
    cpu_pkg::data_t         mem_forward;
    cpu_pkg::data_t         rd_data_wb;

    // fetch
    assign imem_req_o = '{addr: pc_q, wdata: '0, wen: cpu_pkg::DISABLE, ren: cpu_pkg::ENABLE};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `RESET_PC;
        end else if (redirect_ex) begin
            pc_q <= pc_target_ex;
        end else if (!stall_if && !global_stall_c_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_if_id) begin
            if_id_q <= '0;
        end else if (stall_if) begin
            if_id_q <= if_id_q;
        end else if (global_stall_c_i) begin
            // fetch lost the bus, insert a bubble
            if_id_q <= '0;
        end else begin
            if_id_q <= '{pc: pc_q, pc_next: pc_q + 32'd4, instruction: imem_data_i};
        end
    end

    // decode
    decoder u_decoder (
        .instruction_i(if_id_q.instruction),
        .rs1_o        (id_ex_d.rs1),
        .rs2_o        (id_ex_d.rs2),
        .rd_o         (id_ex_d.rd),
        .imm_o        (id_ex_d.imm),
        .ctrl_o       (id_ex_d.ctrl)
    );

    regfile u_regfile (
        .clk       (clk),
        .wen_i     (mem_wb_q.reg_write == cpu_pkg::ENABLE),
        .rs1_i     (id_ex_d.rs1),
        .rs2_i     (id_ex_d.rs2),
        .rd_i      (mem_wb_q.rd),
        .rd_data_i (rd_data_wb),
        .rs1_data_o(id_ex_d.rs1_data),
        .rs2_data_o(id_ex_d.rs2_data)
    );

    assign id_ex_d.pc      = if_id_q.pc;
    assign id_ex_d.pc_next = if_id_q.pc_next;

    always_ff @(posedge clk) begin
        if (rst_i || flush_id_ex) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    // execute
    execute u_execute (
        .id_ex_i      (id_ex_q),
        .mem_forward_i(mem_forward),
        .wb_forward_i (rd_data_wb),
        .rs1_sel_i    (rs1_sel_ex),
        .rs2_sel_i    (rs2_sel_ex),
        .alu_result_o (alu_result_ex),
        .store_data_o (store_data_ex),
        .pc_target_o  (pc_target_ex),
        .redirect_o   (redirect_ex)
    );

    hazard_unit u_hazard_unit (
        .rs1_id_i       (id_ex_d.rs1),
        .rs2_id_i       (id_ex_d.rs2),
        .id_ex_i        (id_ex_q),
        .rd_mem_i       (ex_mem_q.rd),
        .rd_wb_i        (mem_wb_q.rd),
        .reg_write_mem_i(ex_mem_q.reg_write == cpu_pkg::ENABLE),
        .reg_write_wb_i (mem_wb_q.reg_write == cpu_pkg::ENABLE),
        .redirect_i     (redirect_ex),
        .stall_if_o     (stall_if),
        .flush_if_id_o  (flush_if_id),
        .flush_id_ex_o  (flush_id_ex),
        .rs1_sel_o      (rs1_sel_ex),
        .rs2_sel_o      (rs2_sel_ex)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= '{alu_result:     alu_result_ex,
                          mem_write_data: store_data_ex,
                          rd:             id_ex_q.rd,
                          pc_next:        id_ex_q.pc_next,
                          mem_read:       id_ex_q.ctrl.mem_read,
                          mem_write:      id_ex_q.ctrl.mem_write,
                          reg_write:      id_ex_q.ctrl.reg_write,
                          wb_data_sel:    id_ex_q.ctrl.wb_data_sel};
        end
    end

    // memory stage
    assign dmem_req_o = '{addr:  ex_mem_q.alu_result,
                          wdata: ex_mem_q.mem_write_data,
                          wen:   ex_mem_q.mem_write,
                          ren:   ex_mem_q.mem_read};

    // a link value in MEM forwards as pc_next
    assign mem_forward = (ex_mem_q.wb_data_sel == cpu_pkg::WB_PC_NEXT) ?
                         ex_mem_q.pc_next : ex_mem_q.alu_result;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= '{alu_result:    ex_mem_q.alu_result,
                          mem_read_data: dmem_read_data_i,
                          rd:            ex_mem_q.rd,
                          pc_next:       ex_mem_q.pc_next,
                          reg_write:     ex_mem_q.reg_write,
                          wb_data_sel:   ex_mem_q.wb_data_sel};
        end
    end

    // write back
    always_comb begin
        case (mem_wb_q.wb_data_sel)
            cpu_pkg::WB_MEM:     rd_data_wb = mem_wb_q.mem_read_data;
            cpu_pkg::WB_PC_NEXT: rd_data_wb = mem_wb_q.pc_next;
            default:             rd_data_wb = mem_wb_q.alu_result;
        endcase
    end

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_i,
    input  cpu_pkg::mem_req_t load_req_i,
    input  cpu_pkg::mem_req_t data_req_i,
    input  cpu_pkg::mem_req_t fetch_req_i,
    output cpu_pkg::mem_req_t mem_req_o,
    output logic              fetch_stall_o
);

    logic load_active;
    logic data_active;
    logic data_grant;
    logic data_last_q;

    assign load_active = (load_req_i.wen == cpu_pkg::ENABLE) ||
                         (load_req_i.ren == cpu_pkg::ENABLE);
    assign data_active = (data_req_i.wen == cpu_pkg::ENABLE) ||
                         (data_req_i.ren == cpu_pkg::ENABLE);

    // a read right behind a granted data access yields to a waiting fetch
    assign data_grant = data_active && !load_active &&
                        !(data_last_q && data_req_i.wen == cpu_pkg::DISABLE &&
                          fetch_req_i.ren == cpu_pkg::ENABLE);

    always_comb begin
        if (load_active) begin
            mem_req_o = load_req_i;
        end else if (data_grant) begin
            mem_req_o = data_req_i;
        end else begin
            mem_req_o = fetch_req_i;
        end
    end

    assign fetch_stall_o = (fetch_req_i.ren == cpu_pkg::ENABLE) && (load_active || data_grant);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            data_last_q <= 1'b0;
        end else begin
            data_last_q <= data_grant;
        end
    end

endmodule

// File: verilog/unified_memory.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module unified_memory (
    input  logic              clk,
    input  cpu_pkg::mem_req_t req_i,
    output cpu_pkg::data_t    rdata_o
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    cpu_pkg::data_t      mem [`MEM_WORDS];
    logic [IDX_W-1:0]    word_idx;

    // byte address to word index
    assign word_idx = req_i.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (req_i.wen == cpu_pkg::ENABLE) begin
            mem[word_idx] <= req_i.wdata;
        end
    end

    assign rdata_o = mem[word_idx];

endmodule

// File: verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           prog_we_i,
    input  cpu_pkg::addr_t prog_addr_i,
    input  cpu_pkg::data_t prog_data_i,
    output logic           store_valid_o,
    output cpu_pkg::addr_t store_addr_o,
    output cpu_pkg::data_t store_data_o
);

    cpu_pkg::mem_req_t load_req;
    cpu_pkg::mem_req_t imem_req;
    cpu_pkg::mem_req_t dmem_req;
    cpu_pkg::mem_req_t mem_bus;
    cpu_pkg::data_t    mem_rdata;
    logic              fetch_stall;

    assign load_req = '{addr:  prog_addr_i,
                        wdata: prog_data_i,
                        wen:   prog_we_i ? cpu_pkg::ENABLE : cpu_pkg::DISABLE,
                        ren:   cpu_pkg::DISABLE};

    cpu u_cpu (
        .clk             (clk),
        .rst_i           (rst_i),
        .global_stall_c_i(fetch_stall),
        .imem_req_o      (imem_req),
        .imem_data_i     (mem_rdata),
        .dmem_req_o      (dmem_req),
        .dmem_read_data_i(mem_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .rst_i        (rst_i),
        .load_req_i   (load_req),
        .data_req_i   (dmem_req),
        .fetch_req_i  (imem_req),
        .mem_req_o    (mem_bus),
        .fetch_stall_o(fetch_stall)
    );

    unified_memory u_unified_memory (
        .clk    (clk),
        .req_i  (mem_bus),
        .rdata_o(mem_rdata)
    );

    // only core stores reach the trace
    assign store_valid_o = (mem_bus.wen == cpu_pkg::ENABLE) && !prog_we_i;
    assign store_addr_o  = mem_bus.addr;
    assign store_data_o  = mem_bus.wdata;

endmodule

// File: tests/tb_soc.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_soc;

    localparam logic [31:0] DATA_BASE        = 32'h0000_0400;
    localparam int          CYCLES_PER_INSTR = 40;
    localparam int          QUIET_CYCLES     = 20;
    localparam int          LOOP_COUNT       = 4;
    localparam logic [6:0]  OPC_IMM          = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD         = 7'b0000011;
    localparam logic [6:0]  OPC_JALR         = 7'b1100111;

    logic           clk;
    logic           rst_i;
    logic           prog_we_i;
    cpu_pkg::addr_t prog_addr_i;
    cpu_pkg::data_t prog_data_i;
    logic           store_valid_o;
    cpu_pkg::addr_t store_addr_o;
    cpu_pkg::data_t store_data_o;

    logic [31:0] prog [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] rng;

    soc_top DUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .prog_we_i    (prog_we_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .store_valid_o(store_valid_o),
        .store_addr_o (store_addr_o),
        .store_data_o (store_data_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // RV32I instruction formats
    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] next_instr_addr();
        return `RESET_PC + 32'(prog.size() * 4);
    endfunction

    task automatic emit_instr(input logic [31:0] instr);
        prog.push_back(instr);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // sw rs2, off(x10) that must reach the bus
    task automatic store_word(input int rs2, input int off, input logic [31:0] data);
        emit_instr(s_type(rs2, 10, off));
        expect_store(DATA_BASE + 32'(off), data);
    endtask

    // lui upper part rounded for the sign of the low 12 bits
    task automatic set_const(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        emit_instr(u_type(rd, int'(upper)));
        emit_instr(i_type(OPC_IMM, 0, rd, rd, int'(value[11:0])));
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] res_or;
        logic [31:0] upper;
        logic [31:0] val;
        logic [31:0] link;
        logic [31:0] loop_pc;
        logic [11:0] c;
        a = next_rand();
        b = next_rand();
        c = 12'(next_rand());
        upper = next_rand();
        sum = a + b;
        diff = a - sum;
        res_or = (diff & sum) | b;
        emit_instr(i_type(OPC_IMM, 0, 10, 0, int'(DATA_BASE)));
        // each ALU result feeds the next instruction
        set_const(1, a);
        set_const(2, b);
        emit_instr(r_type(0, 0, 3, 1, 2));
        emit_instr(r_type(32, 0, 4, 1, 3));
        emit_instr(r_type(0, 7, 5, 4, 3));
        emit_instr(r_type(0, 6, 6, 5, 2));
        emit_instr(r_type(0, 2, 7, 4, 1));
        emit_instr(r_type(0, 2, 8, 1, 4));
        emit_instr(i_type(OPC_IMM, 0, 9, 6, int'(c)));
        emit_instr(u_type(11, int'(upper[19:0])));
        emit_instr(r_type(0, 0, 12, 11, 9));
        store_word(3, 0, sum);
        store_word(4, 4, diff);
        store_word(5, 8, diff & sum);
        store_word(6, 12, res_or);
        store_word(7, 16, {31'b0, $signed(diff) < $signed(a)});
        store_word(8, 20, {31'b0, $signed(a) < $signed(diff)});
        store_word(9, 24, res_or + sext12(c));
        store_word(12, 28, {upper[19:0], 12'b0} + res_or + sext12(c));
        // load followed at once by its use
        // the nop keeps each load off the cycle after a data access
        c = 12'(next_rand());
        val = sum + sext12(c);
        emit_instr(i_type(OPC_IMM, 0, 0, 0, 0));
        emit_instr(i_type(OPC_LOAD, 2, 13, 10, 0));
        emit_instr(i_type(OPC_IMM, 0, 14, 13, int'(c)));
        store_word(14, 32, val);
        emit_instr(i_type(OPC_IMM, 0, 0, 0, 0));
        emit_instr(i_type(OPC_LOAD, 2, 15, 10, 32));
        emit_instr(r_type(0, 0, 16, 15, 15));
        store_word(16, 36, val << 1);
        // skipped stores behind the branches would write zero
        val = next_rand() | 32'd1;
        set_const(17, val);
        emit_instr(i_type(OPC_IMM, 0, 18, 17, 0));
        emit_instr(b_type(0, 17, 18, 12));
        emit_instr(s_type(0, 10, 40));
        emit_instr(s_type(0, 10, 44));
        emit_instr(b_type(1, 17, 18, 12));
        store_word(17, 40, val);
        store_word(18, 44, val);
        emit_instr(b_type(1, 17, 0, 12));
        emit_instr(s_type(0, 10, 48));
        emit_instr(s_type(0, 10, 52));
        emit_instr(b_type(0, 17, 0, 12));
        store_word(17, 48, val);
        // jal skips one store and links to its own address plus 4
        link = next_instr_addr() + 4;
        emit_instr(j_type(19, 8));
        emit_instr(s_type(0, 10, 56));
        store_word(19, 56, link);
        // jalr follows the addi and lands 12 bytes past itself
        link = next_instr_addr() + 8;
        emit_instr(i_type(OPC_IMM, 0, 20, 0, int'(link + 32'd8)));
        emit_instr(i_type(OPC_JALR, 0, 21, 20, 0));
        emit_instr(s_type(0, 10, 60));
        emit_instr(s_type(0, 10, 60));
        store_word(21, 60, link);
        // store, read back and bump in a loop
        val = next_rand();
        c = 12'(next_rand());
        set_const(22, val);
        emit_instr(i_type(OPC_IMM, 0, 23, 0, LOOP_COUNT));
        emit_instr(i_type(OPC_IMM, 0, 24, 10, 64));
        loop_pc = next_instr_addr();
        emit_instr(s_type(22, 24, 0));
        emit_instr(i_type(OPC_IMM, 0, 24, 24, 4));
        emit_instr(i_type(OPC_LOAD, 2, 25, 24, -4));
        emit_instr(i_type(OPC_IMM, 0, 22, 25, int'(c)));
        emit_instr(i_type(OPC_IMM, 0, 23, 23, -1));
        emit_instr(b_type(1, 23, 0, int'(loop_pc - next_instr_addr())));
        emit_instr(s_type(22, 24, 0));
        for (int i = 0; i <= LOOP_COUNT; i++) begin
            expect_store(DATA_BASE + 32'd64 + 32'(4 * i), val + 32'(i) * sext12(c));
        end
        // park the core
        emit_instr(j_type(0, 0));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            prog_we_i   = 1'b1;
            prog_addr_i = `RESET_PC + 32'(i * 4);
            prog_data_i = prog[i];
        end
        @(negedge clk);
        prog_we_i = 1'b0;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_store();
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        assert (exp_addr_q.size() != 0)
            else abort_run($sformatf("unexpected store of %h to %h at %0t with none pending",
                                     store_data_o, store_addr_o, $time));
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        assert (store_addr_o == exp_addr)
            else abort_run($sformatf("FAILED at %0t: store_addr_o is %h, expected %h",
                                     $time, store_addr_o, exp_addr));
        assert (store_data_o == exp_data)
            else abort_run($sformatf("FAILED at %0t: store_data_o is %h, expected %h",
                                     $time, store_data_o, exp_data));
    endtask

    // each store is checked at the edge that writes it
    always @(posedge clk) begin
        if (!rst_i && store_valid_o) begin
            check_store();
        end
    end

    initial begin
        @(negedge rst_i);
        repeat (prog.size() * CYCLES_PER_INSTR) @(posedge clk);
        $display("timeout, %0d expected stores still pending", exp_addr_q.size());
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        rng         = 32'h94ea;
        build_program();
        repeat (2) @(posedge clk);
        load_program();
        rst_i = 1'b0;
        while (exp_addr_q.size() != 0) begin
            @(posedge clk);
        end
        // any stray store from here on trips the checker
        repeat (QUIET_CYCLES) @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
verilog/cpu_pkg.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/execute.sv
verilog/hazard_unit.sv
verilog/cpu.sv
verilog/mem_arbiter.sv
verilog/unified_memory.sv
verilog/soc_top.sv
tests/tb_soc.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_soc
FLIST     := flist.f
OBJDIR    := obj_dir
PASS_MSG  := Testbench passed

.PHONY: sim clean

# the run passes only when the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)
